// ==== include/timer_ref_model.svh ====
`ifndef TIMER_REF_MODEL_SVH
`define TIMER_REF_MODEL_SVH

logic [31:0] lfsr_state = 32'h6929_7e76;   // Fixed seed, repeatable runs

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// One step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

// Status byte: irq is the OR of the two flags
function automatic bus_data_t expected_status(input logic flag1, input logic flag2);
    bus_data_t s;
    s = '0;
    s[STATUS_IRQ_BIT]   = flag1 | flag2;
    s[STATUS_FLAG1_BIT] = flag1;
    s[STATUS_FLAG2_BIT] = flag2;
    return s;
endfunction

// Clocks from load to overflow
function automatic int overflow_cycles(input timer_val_t preset, input int tick);
    return (256 - int'(preset)) * tick;
endfunction

task automatic check_status(input bus_data_t got, input bus_data_t exp, input string what);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("FAIL %0t ns: %s, status 0x%02h expected 0x%02h", $time, what, got, exp);
    end
endtask

task automatic check_irq_n(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("FAIL %0t ns: %s, irq_n %b expected %b", $time, what, got, exp);
    end
endtask

task automatic check_fall_time(input int got, input int exp, input string what);
    check_count++;
    if (got < exp - FALL_TOL || got > exp + FALL_TOL) begin
        err_count++;
        $display("FAIL %0t ns: %s, irq_n fell after %0d cycles, expected %0d +/- %0d",
                 $time, what, got, exp, FALL_TOL);
    end
endtask

`endif

// ==== dv/tb_opl3_timer.sv ====
`timescale 1ns/1ps

module tb_opl3_timer;
    import opl3_timer_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int IRQ_LATENCY = 4;     // Strobe, load, flag and irq_n registers
    localparam int FALL_TOL    = 4;
    localparam int P1_MAX      = 16 * TIMER1_TICK_INTERVAL;  // Presets 0xF0 and up
    localparam int P2_MAX      = 16 * TIMER2_TICK_INTERVAL;
    // Tests 2 to 6 back to back, worst case, plus slack for bus traffic
    localparam int WATCHDOG_CYCLES = P1_MAX + 8 * P2_MAX + 400;

    logic      clk;
    logic      reset;
    logic      bus_wr;
    logic      bus_rd;
    bus_port_t bus_port;
    bus_data_t bus_din;
    bus_data_t bus_dout;
    logic      irq_n;

    int err_count   = 0;
    int check_count = 0;
    int tests_ok    = 0;
    int tests_bad   = 0;
    int test_num    = 0;
    int test_errs   = 0;     // err_count when the test began

    `include "timer_ref_model.svh"

    opl3_timer_top u_dut (
        .clk     (clk),
        .reset   (reset),
        .bus_wr  (bus_wr),
        .bus_rd  (bus_rd),
        .bus_port(bus_port),
        .bus_din (bus_din),
        .bus_dout(bus_dout),
        .irq_n   (irq_n)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(longint'(WATCHDOG_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    // All bus tasks start and end on a falling edge
    task automatic bus_write(input bus_port_t port, input bus_data_t data);
        bus_wr   = 1'b1;
        bus_port = port;
        bus_din  = data;
        @(negedge clk);
        bus_wr   = 1'b0;
    endtask

    task automatic write_reg(input reg_bank_t bank, input reg_addr_t addr, input bus_data_t data);
        bus_write({bank, 1'b0}, addr);    // Address port
        bus_write({bank, 1'b1}, data);    // Data port makes the strobe
    endtask

    task automatic read_status(output bus_data_t val);
        bus_rd = 1'b1;
        @(negedge clk);
        bus_rd = 1'b0;
        @(negedge clk);
        val = bus_dout;                    // Registered one edge after the strobe
    endtask

    function automatic bus_data_t ctrl_byte(input logic rst, input logic en1, input logic en2,
                                            input logic st2, input logic st1);
        bus_data_t c;
        c = '0;
        c[CTRL_IRQ_RST_BIT]  = rst;
        c[CTRL_FLAG1_EN_BIT] = en1;
        c[CTRL_FLAG2_EN_BIT] = en2;
        c[CTRL_START2_BIT]   = st2;
        c[CTRL_START1_BIT]   = st1;
        return c;
    endfunction

    // Stops both timers and clears the flags
    task automatic clear_flags();
        write_reg(1'b0, REG_TIMER_CTRL_ADDR, ctrl_byte(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
        write_reg(1'b0, REG_TIMER_CTRL_ADDR, 8'h00);   // Release the IRQ reset
        repeat (2) @(negedge clk);
    endtask

    task automatic wait_irq_fall(input int limit, output int cycles);
        cycles = 0;
        while (irq_n !== 1'b0 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (irq_n !== 1'b0) begin
            err_count++;
            $display("irq_n did not fall within %0d cycles at %0t ns", limit, $time);
        end
    endtask

    // irq_n must stay high; first glitch is reported
    task automatic hold_quiet(input int cycles, input string what);
        logic level;
        level = 1'b1;
        for (int i = 0; i < cycles && level === 1'b1; i++) begin
            @(negedge clk);
            level = irq_n;                 // Stops at the first low
        end
        check_irq_n(level, 1'b1, what);
    endtask

    task automatic test_start();
        test_num++;
        test_errs = err_count;
    endtask

    task automatic test_end(input string name);
        if (err_count == test_errs) begin
            tests_ok++;
            $display("test %0d %s: passed", test_num, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: failed, %0d errors", test_num, name, err_count - test_errs);
        end
    endtask

    initial begin
        bus_data_t   st;
        timer_val_t  p1;
        timer_val_t  p2;
        logic [31:0] r;
        int          n;
        int          per1;
        int          per2;
        int          longest;

        $timeformat(-9, 0, "", 0);
        reset    = 1'b1;
        bus_wr   = 1'b0;
        bus_rd   = 1'b0;
        bus_port = '0;
        bus_din  = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_start();
        check_irq_n(irq_n, 1'b1, "after reset");
        read_status(st);
        check_status(st, 8'h00, "after reset");
        test_end("reset values");

        test_start();
        r    = rand_bits(4);
        p1   = {4'hF, r[3:0]};               // Keep the period short
        per1 = overflow_cycles(p1, TIMER1_TICK_INTERVAL);
        write_reg(1'b0, REG_TIMER1_ADDR, p1);
        write_reg(1'b0, REG_TIMER_CTRL_ADDR, ctrl_byte(1'b0, 1'b1, 1'b0, 1'b0, 1'b1));
        wait_irq_fall(per1 + IRQ_LATENCY + FALL_TOL, n);
        check_fall_time(n, per1 + IRQ_LATENCY, "timer 1 overflow");
        read_status(st);
        check_status(st, expected_status(1'b1, 1'b0), "timer 1 flag");
        test_end("timer 1 overflow");

        test_start();
        clear_flags();
        check_irq_n(irq_n, 1'b1, "flags cleared before timer 2");
        r    = rand_bits(4);
        p2   = {4'hF, r[3:0]};
        per2 = overflow_cycles(p2, TIMER2_TICK_INTERVAL);
        write_reg(1'b0, REG_TIMER2_ADDR, p2);
        write_reg(1'b0, REG_TIMER_CTRL_ADDR, ctrl_byte(1'b0, 1'b0, 1'b1, 1'b1, 1'b0));
        wait_irq_fall(per2 + IRQ_LATENCY + FALL_TOL, n);
        check_fall_time(n, per2 + IRQ_LATENCY, "timer 2 overflow");
        read_status(st);
        check_status(st, expected_status(1'b0, 1'b1), "timer 2 flag");
        test_end("timer 2 overflow");

        longest = (per1 > per2) ? per1 : per2;

        test_start();
        clear_flags();
        write_reg(1'b0, REG_TIMER_CTRL_ADDR, ctrl_byte(1'b0, 1'b0, 1'b0, 1'b1, 1'b1));
        hold_quiet(2 * longest + IRQ_LATENCY, "both running, flags masked");
        read_status(st);
        check_status(st, 8'h00, "both running, flags masked");
        test_end("masked flags");

        test_start();
        clear_flags();
        write_reg(1'b0, REG_TIMER_CTRL_ADDR, ctrl_byte(1'b0, 1'b1, 1'b1, 1'b1, 1'b1));
        wait_irq_fall(longest + IRQ_LATENCY + FALL_TOL, n);
        repeat (longest + IRQ_LATENCY) @(negedge clk);  // Room for the slower flag
        read_status(st);
        check_status(st, expected_status(1'b1, 1'b1), "both flags set");
        write_reg(1'b0, REG_TIMER_CTRL_ADDR, ctrl_byte(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
        repeat (4) @(negedge clk);
        check_irq_n(irq_n, 1'b1, "after irq reset");
        read_status(st);
        check_status(st, 8'h00, "after irq reset");
        write_reg(1'b0, REG_TIMER_CTRL_ADDR, ctrl_byte(1'b0, 1'b1, 1'b1, 1'b1, 1'b1));
        repeat (longest + IRQ_LATENCY + FALL_TOL) @(negedge clk);
        read_status(st);
        check_status(st, expected_status(1'b1, 1'b1), "flags after restart");
        check_irq_n(irq_n, 1'b0, "flags after restart");
        test_end("irq reset and restart");

        test_start();
        clear_flags();
        write_reg(1'b1, REG_TIMER1_ADDR, 8'hFF);   // Bank 1 copies of the timer registers
        write_reg(1'b1, REG_TIMER2_ADDR, 8'hFF);
        write_reg(1'b1, REG_TIMER_CTRL_ADDR, ctrl_byte(1'b0, 1'b1, 1'b1, 1'b1, 1'b1));
        hold_quiet(2 * longest + IRQ_LATENCY, "bank 1 writes");
        read_status(st);
        check_status(st, 8'h00, "bank 1 writes");
        test_end("bank 1 ignored");

        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_ok, tests_bad, check_count, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the timer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_opl3_timer -f tb.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

# Pass only if the testbench printed the pass line
grep -q '^>>> PASS$' sim.log
echo "simulation passed"

// ==== tb.f ====
+incdir+include
verilog/opl3_timer_pkg.sv
verilog/timer.sv
verilog/timers.sv
verilog/host_bus_if.sv
verilog/opl3_timer_top.sv
dv/tb_opl3_timer.sv

// ==== verilog/host_bus_if.sv ====
`timescale 1ns/1ps

module host_bus_if (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      bus_wr,        // One-cycle CPU write strobe
    input  logic                      bus_rd,        // One-cycle CPU read strobe
    input  opl3_timer_pkg::bus_port_t bus_port,
    input  opl3_timer_pkg::bus_data_t bus_din,
    input  opl3_timer_pkg::bus_data_t status,        // From timer block
    output opl3_timer_pkg::bus_data_t bus_dout,
    output logic                      reg_wr_valid,
    output opl3_timer_pkg::reg_bank_t reg_wr_bank,
    output opl3_timer_pkg::reg_addr_t reg_wr_addr,
    output opl3_timer_pkg::bus_data_t reg_wr_data
);
    import opl3_timer_pkg::*;

    reg_addr_t addr_q;       // Last address written, kept for many data writes
    reg_bank_t bank_q;
    logic      addr_wr;
    logic      data_wr;

    // Port bit 0 picks address or data
    assign addr_wr = bus_wr && !bus_port[PORT_DATA_BIT];
    assign data_wr = bus_wr && bus_port[PORT_DATA_BIT];

    // Address and bank latch
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_q <= '0;
            bank_q <= '0;
        end else if (addr_wr) begin
            addr_q <= bus_din;
            bank_q <= bus_port[PORT_BANK_BIT];  // Bank comes with the address write
        end
    end

    // Write strobe, one cycle per data-port write
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_wr_valid <= 1'b0;
            reg_wr_bank  <= '0;
            reg_wr_addr  <= '0;
        end else begin
            reg_wr_valid <= data_wr;
            if (data_wr) begin
                reg_wr_bank <= bank_q;     // Snapshot so a following address
                reg_wr_addr <= addr_q;     // write can't disturb this strobe
            end
        end
    end

    // Data byte rides with the strobe
    always_ff @(posedge clk) begin
        if (data_wr) begin
            reg_wr_data <= bus_din;
        end
    end

    // Read data held until the next read
    always_ff @(posedge clk) begin
        if (reset) begin
            bus_dout <= '0;
        end else if (bus_rd) begin
            bus_dout <= status;            // Status is the only readable byte
        end
    end

endmodule

// ==== verilog/opl3_timer_pkg.sv ====
package opl3_timer_pkg;

    // Bus and register widths
    localparam int BUS_DATA_WIDTH = 8;
    localparam int BUS_PORT_WIDTH = 2;
    localparam int REG_ADDR_WIDTH = 8;
    localparam int REG_BANK_WIDTH = 1;
    localparam int TIMER_WIDTH    = 8;

    typedef logic [BUS_DATA_WIDTH-1:0] bus_data_t;   // CPU byte and register data
    typedef logic [BUS_PORT_WIDTH-1:0] bus_port_t;   // Port select from the CPU
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;   // Register address in a bank
    typedef logic [REG_BANK_WIDTH-1:0] reg_bank_t;   // Bank 0 or bank 1
    typedef logic [TIMER_WIDTH-1:0]    timer_val_t;  // Timer preset and count

    // Port select bits
    localparam int PORT_DATA_BIT = 0;                // 0 address port, 1 data port
    localparam int PORT_BANK_BIT = 1;

    // Timer register addresses, bank 0 only
    localparam reg_addr_t REG_TIMER1_ADDR     = 8'h02;
    localparam reg_addr_t REG_TIMER2_ADDR     = 8'h03;
    localparam reg_addr_t REG_TIMER_CTRL_ADDR = 8'h04;

    // Bank that holds the timer registers
    localparam reg_bank_t TIMER_BANK = 1'b0;

    // Control byte fields
    localparam int CTRL_IRQ_RST_BIT  = 7;            // Clears both flags while set
    localparam int CTRL_FLAG1_EN_BIT = 6;
    localparam int CTRL_FLAG2_EN_BIT = 5;
    localparam int CTRL_START2_BIT   = 1;
    localparam int CTRL_START1_BIT   = 0;

    // Status byte fields, the rest read as zero
    localparam int STATUS_IRQ_BIT   = 7;
    localparam int STATUS_FLAG1_BIT = 6;
    localparam int STATUS_FLAG2_BIT = 5;

    // Clocks per counter tick
    // Much shorter than the chip so runs stay quick, same 1:4 ratio
    localparam int TIMER1_TICK_INTERVAL = 4;
    localparam int TIMER2_TICK_INTERVAL = 16;

endpackage

// ==== verilog/opl3_timer_top.sv ====
`timescale 1ns/1ps

module opl3_timer_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      bus_wr,
    input  logic                      bus_rd,
    input  opl3_timer_pkg::bus_port_t bus_port,
    input  opl3_timer_pkg::bus_data_t bus_din,
    output opl3_timer_pkg::bus_data_t bus_dout,
    output logic                      irq_n
);
    import opl3_timer_pkg::*;

    // Register write path, host to timers
    logic      reg_wr_valid;
    reg_bank_t reg_wr_bank;
    reg_addr_t reg_wr_addr;
    bus_data_t reg_wr_data;
    bus_data_t status;         // Back to the host for reads

    host_bus_if u_host (
        .clk         (clk),
        .reset       (reset),
        .bus_wr      (bus_wr),
        .bus_rd      (bus_rd),
        .bus_port    (bus_port),
        .bus_din     (bus_din),
        .status      (status),
        .bus_dout    (bus_dout),
        .reg_wr_valid(reg_wr_valid),
        .reg_wr_bank (reg_wr_bank),
        .reg_wr_addr (reg_wr_addr),
        .reg_wr_data (reg_wr_data)
    );

    timers u_timers (
        .clk         (clk),
        .reset       (reset),
        .reg_wr_valid(reg_wr_valid),
        .reg_wr_bank (reg_wr_bank),
        .reg_wr_addr (reg_wr_addr),
        .reg_wr_data (reg_wr_data),
        .irq_n       (irq_n),
        .status      (status)
    );

endmodule

// ==== verilog/timer.sv ====
`timescale 1ns/1ps

module timer #(
    parameter int TICK_INTERVAL = 4                  // Clocks per counter tick
) (
    input  logic                       clk,
    input  logic                       reset,
    input  opl3_timer_pkg::timer_val_t preset,       // Load and reload value
    input  logic                       start,        // Level, count while high
    output logic                       overflow_pulse
);
    import opl3_timer_pkg::*;

    localparam int PRESCALE_WIDTH = (TICK_INTERVAL > 1) ? $clog2(TICK_INTERVAL) : 1;
    localparam logic [PRESCALE_WIDTH-1:0] PRESCALE_LAST = PRESCALE_WIDTH'(TICK_INTERVAL - 1);

    logic [PRESCALE_WIDTH-1:0] prescale_cnt;
    logic                      tick;
    logic                      start_q;
    logic                      start_rise;
    timer_val_t                count;

    assign start_rise = start && !start_q;
    assign tick       = start && (prescale_cnt == PRESCALE_LAST);

    // Edge detect on start
    always_ff @(posedge clk) begin
        if (reset) begin
            start_q <= 1'b0;
        end else begin
            start_q <= start;
        end
    end

    // Prescaler, wraps every TICK_INTERVAL clocks
    always_ff @(posedge clk) begin
        if (reset || start_rise || !start) begin
            prescale_cnt <= '0;            // Restart the interval on each start
        end else if (tick) begin
            prescale_cnt <= '0;
        end else begin
            prescale_cnt <= prescale_cnt + 1'b1;
        end
    end

    // Up-counter with reload
    // Overflow period is (256 - preset) ticks from the load
    always_ff @(posedge clk) begin
        if (reset) begin
            count          <= '0;
            overflow_pulse <= 1'b0;
        end else begin
            overflow_pulse <= 1'b0;        // Default, single-cycle pulse
            if (start_rise) begin
                count <= preset;
            end else if (tick) begin
                if (count == '1) begin
                    count          <= preset;  // Wrap back to preset, not zero
                    overflow_pulse <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

endmodule

// ==== verilog/timers.sv ====
`timescale 1ns/1ps

module timers (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      reg_wr_valid,
    input  opl3_timer_pkg::reg_bank_t reg_wr_bank,
    input  opl3_timer_pkg::reg_addr_t reg_wr_addr,
    input  opl3_timer_pkg::bus_data_t reg_wr_data,
    output logic                      irq_n,         // Active low, registered
    output opl3_timer_pkg::bus_data_t status
);
    import opl3_timer_pkg::*;

    timer_val_t timer1_preset;
    timer_val_t timer2_preset;
    logic       irq_rst;        // Holds flags clear until rewritten
    logic       flag1_en;
    logic       flag2_en;
    logic       start1;
    logic       start2;
    logic       timer1_overflow_pulse;
    logic       timer2_overflow_pulse;
    logic       flag1;
    logic       flag2;
    logic       irq;
    logic       bank_hit;

    // Only bank 0 carries the timer registers
    assign bank_hit = reg_wr_valid && (reg_wr_bank == TIMER_BANK);

    // Register decode, other addresses ignored
    always_ff @(posedge clk) begin
        if (reset) begin
            timer1_preset <= '0;
            timer2_preset <= '0;
            irq_rst       <= 1'b0;
            flag1_en      <= 1'b0;
            flag2_en      <= 1'b0;
            start1        <= 1'b0;
            start2        <= 1'b0;
        end else if (bank_hit) begin
            if (reg_wr_addr == REG_TIMER1_ADDR) begin
                timer1_preset <= reg_wr_data;
            end
            if (reg_wr_addr == REG_TIMER2_ADDR) begin
                timer2_preset <= reg_wr_data;
            end
            if (reg_wr_addr == REG_TIMER_CTRL_ADDR) begin
                irq_rst  <= reg_wr_data[CTRL_IRQ_RST_BIT];
                flag1_en <= reg_wr_data[CTRL_FLAG1_EN_BIT];
                flag2_en <= reg_wr_data[CTRL_FLAG2_EN_BIT];
                start2   <= reg_wr_data[CTRL_START2_BIT];
                start1   <= reg_wr_data[CTRL_START1_BIT];
            end
        end
    end

    timer #(
        .TICK_INTERVAL(TIMER1_TICK_INTERVAL)   // Fast timer
    ) u_timer1 (
        .clk           (clk),
        .reset         (reset),
        .preset        (timer1_preset),
        .start         (start1),
        .overflow_pulse(timer1_overflow_pulse)
    );

    timer #(
        .TICK_INTERVAL(TIMER2_TICK_INTERVAL)   // Slow timer, 4x the tick
    ) u_timer2 (
        .clk           (clk),
        .reset         (reset),
        .preset        (timer2_preset),
        .start         (start2),
        .overflow_pulse(timer2_overflow_pulse)
    );

    // Sticky flags, clear has priority over a new overflow
    always_ff @(posedge clk) begin
        if (reset || irq_rst) begin
            flag1 <= 1'b0;
            flag2 <= 1'b0;
        end else begin
            if (timer1_overflow_pulse && flag1_en) flag1 <= 1'b1;
            if (timer2_overflow_pulse && flag2_en) flag2 <= 1'b1;
        end
    end

    assign irq = flag1 || flag2;

    // Interrupt pin lags the flags by one clock
    always_ff @(posedge clk) begin
        if (reset) begin
            irq_n <= 1'b1;
        end else begin
            irq_n <= !irq;
        end
    end

    // Status byte, unused bits zero
    always_comb begin
        status                   = '0;
        status[STATUS_IRQ_BIT]   = irq;
        status[STATUS_FLAG1_BIT] = flag1;
        status[STATUS_FLAG2_BIT] = flag2;
    end

endmodule
